// File: Makefile
# Verilator build and run for the memory front end testbench

TOP             ?= mem_front_end_tb
FLIST           ?= files.f
VERILATOR       ?= verilator
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mem_front_end_assertions.sv
/*
 * Bus protocol checks for the arbiter, attached with bind from the
 * testbench. Grant and accept routing only.
 */

module mem_front_end_assertions
    import mem_bus_pkg::*, core_pkg::*;
(
    input logic         clock,
    input bus_command_t fetch_command,
    input bus_command_t data_command,
    input bus_command_t proc2mem_command,
    input mem_tag_t     mem2proc_response,
    input logic         fetch_accept,
    input logic         data_accept
);

    // data side owns the bus whenever its command is up
    data_owns_bus: assert property (@(posedge clock)
        (data_command != BUS_NONE) |-> (proc2mem_command == data_command))
        else $error("fetch command on the bus while data command is up");

    // one grant per cycle
    single_accept: assert property (@(posedge clock)
        !(fetch_accept && data_accept))
        else $error("fetch and data accepted in the same cycle");

    accept_needs_response: assert property (@(posedge clock)
        (fetch_accept || data_accept) |-> (mem2proc_response != MEM_TAG_NONE))
        else $error("accept with a zero response");

    // a refused data command stays up unchanged until accepted
    data_held_on_retry: assert property (@(posedge clock)
        (data_command != BUS_NONE && !data_accept) |=> (data_command == $past(data_command)))
        else $error("data command dropped before it was accepted");

endmodule

// File: bench/mem_front_end_stim.txt
# op addr data dest expect, all hex; mem sets an initial low word
# fetch waits for <data> lines, refuse blocks the next <data> responses
mem      00000010 1234abcd 00 00000000
mem      00000018 0f0f5a5a 00 00000000
mem      00001f00 0badf00d 00 00000000
mem      00001f20 600dcafe 00 00000000
fetch    00000000 00000006 00 00000000
load     00001f00 00000000 03 0badf00d
load     00000010 00000000 07 1234abcd
store    00001f08 55aa1234 09 00000000
load     00001f08 00000000 0a 55aa1234
fetch    00000000 00000004 00 00000000
redirect 00000200 00000000 00 00000000
fetch    00000000 00000005 00 00000000
refuse   00000000 00000003 00 00000000
load     00000018 00000000 11 0f0f5a5a
refuse   00000000 00000005 00 00000000
fetch    00000000 00000003 00 00000000
store    00001f10 89abcdef 1f 00000000
refuse   00000000 00000004 00 00000000
load     00001f10 00000000 02 89abcdef
redirect 00000100 00000000 00 00000000
fetch    00000000 00000003 00 00000000
load     00001f20 00000000 15 600dcafe
fetch    00000000 00000002 00 00000000

// File: bench/mem_front_end_tb.sv
/*
 * Testbench for the memory front end. A memory model with random return
 * delay answers the bus, records from the stim file drive the data port,
 * redirects and refused cycles, and every fetch line is checked.
 */

module mem_front_end_tb
    import mem_bus_pkg::*, core_pkg::*;
();

    logic clock, reset;
    mem_tag_t mem2proc_response, mem2proc_tag;
    mem_line_t mem2proc_data, proc2mem_data, fetch_line;
    bus_command_t proc2mem_command;
    addr_t proc2mem_addr, redirect_pc, fetch_pc, data_addr;
    logic redirect, fetch_stall, fetch_valid;
    logic data_req, data_write, data_busy, data_done;
    word_t data_wdata, data_rdata;
    reg_idx_t data_dest, data_done_dest;

    mem_line_t mem_lines [1024];   // 8 KB, indexed by line
    mem_tag_t  next_tag;
    int        refuse_left, cycle, errors, tests, fetch_seen;
    logic [15:0] lfsr_state;
    addr_t     expected_pc;
    mem_tag_t  ret_tag [$];          // pending load returns, in order
    addr_t     ret_addr [$];
    int        ret_due [$];

    mem_front_end i_mem_front_end (.*);

    bind bus_arbiter mem_front_end_assertions i_bus_assertions (
        .clock             (mem_front_end_tb.clock),
        .fetch_command     (fetch_command),
        .data_command      (data_command),
        .proc2mem_command  (proc2mem_command),
        .mem2proc_response (mem2proc_response),
        .fetch_accept      (fetch_accept),
        .data_accept       (data_accept)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic int line_index(input addr_t a);
        return int'(a[12:3]);
    endfunction

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 16'hb400;
        return out;
    endfunction

    task automatic give_up(input string what);
        $display("timeout: %s never happened at time %0t", what, $time);
        $display("tests run: %0d, errors: %0d", tests, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        int delay;
        logic b1, b0;
        cycle = cycle + 1;
        if (proc2mem_command != BUS_NONE && mem2proc_response != MEM_TAG_NONE) begin
            if (proc2mem_command == BUS_STORE) begin
                if (proc2mem_data[63:32] !== 32'h0) begin
                    $display("** Error at %0t: store data %h not zero above the word", $time,
                             proc2mem_data);
                    errors = errors + 1;
                end
                mem_lines[line_index(proc2mem_addr)][31:0] = proc2mem_data[31:0];
            end else begin
                b1 = lfsr_bit();
                b0 = lfsr_bit();
                delay = 1 + int'({b1, b0});    // 1 to 4 cycles
                ret_tag.push_back(mem2proc_response);
                ret_addr.push_back(proc2mem_addr);
                ret_due.push_back(cycle + delay - 1);
            end
            next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // skip zero
        end
        if (ret_due.size() > 0 && ret_due[0] <= cycle) begin  // one return per cycle
            mem2proc_tag  <= ret_tag.pop_front();
            mem2proc_data <= mem_lines[line_index(ret_addr.pop_front())];
            void'(ret_due.pop_front());
        end else begin
            mem2proc_tag <= MEM_TAG_NONE;
        end
        if (refuse_left > 0) begin
            mem2proc_response <= MEM_TAG_NONE;   // refused, requester retries
            refuse_left = refuse_left - 1;
        end else begin
            mem2proc_response <= next_tag;
        end
    end

    // fetch monitor, lines must come in PC order
    always @(posedge clock) begin
        if (!reset && fetch_valid) begin
            fetch_seen = fetch_seen + 1;
            if (fetch_pc !== expected_pc) begin
                $display("** Error at %0t: fetch pc %h, expected %h", $time, fetch_pc,
                         expected_pc);
                errors = errors + 1;
            end else if (fetch_line !== mem_lines[line_index(fetch_pc)]) begin
                $display("** Error at %0t: fetch line %h at pc %h", $time, fetch_line,
                         fetch_pc);
                errors = errors + 1;
            end
            expected_pc = expected_pc + addr_t'(MEM_LINE_BYTES);  // next line in order
        end
        if (!reset && redirect) expected_pc = redirect_pc;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int fd, n, i, k, start, errors_before;
        string text, op;
        string ops [$];
        logic [31:0] fa, fd_data, fdest, fexp;
        addr_t addrs [$];
        word_t datas [$], expects [$];
        reg_idx_t dests [$];
        // every input known from time zero
        reset = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        fetch_stall = 1'b0;
        data_req = 1'b0;
        data_write = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_dest = '0;
        mem2proc_response = MEM_TAG_NONE;
        mem2proc_tag = MEM_TAG_NONE;
        mem2proc_data = '0;
        next_tag = 4'h1;
        refuse_left = 0;
        cycle = 0;
        errors = 0;
        tests = 0;
        fetch_seen = 0;
        lfsr_state = 16'd25048;
        expected_pc = FETCH_RESET_PC;
        for (i = 0; i < 1024; i++) begin
            mem_lines[i] = {32'(i * 8) ^ 32'hc0de_0000, ~32'(i * 8)};  // whole address
        end
        fd = $fopen("bench/mem_front_end_stim.txt", "r");
        if (fd == 0) give_up("opening the stim file");
        while (!$feof(fd)) begin
            if ($fgets(text, fd) == 0) break;
            if (text.len() < 2 || text[0] == "#") continue;
            n = $sscanf(text, "%s %h %h %h %h", op, fa, fd_data, fdest, fexp);
            if (n != 5) continue;
            if (op == "mem") begin
                mem_lines[line_index(fa)][31:0] = fd_data;   // initial words
            end else begin
                ops.push_back(op);
                addrs.push_back(fa);
                datas.push_back(fd_data);
                dests.push_back(reg_idx_t'(fdest));
                expects.push_back(fexp);
            end
        end
        $fclose(fd);

        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);   // samples the first cycle out of reset
        tests = tests + 1;
        if (fetch_valid || data_done || data_busy || proc2mem_command != BUS_NONE) begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            errors = errors + 1;
        end
        $display("test %0d reset: done", tests);

        for (i = 0; i < ops.size(); i++) begin
            errors_before = errors;
            tests = tests + 1;
            if (ops[i] == "fetch") begin
                start = fetch_seen;
                k = 0;
                while (fetch_seen < start + int'(datas[i])) begin
                    @(posedge clock);
                    k++;
                    if (k > 400) give_up("fetch lines");
                end
            end else if (ops[i] == "refuse") begin
                refuse_left = int'(datas[i]);
            end else if (ops[i] == "redirect") begin
                k = 0;
                forever begin   // wait for a fetch acceptance
                    @(posedge clock);
                    k++;
                    if (k > 200) give_up("fetch acceptance before redirect");
                    if (proc2mem_command == BUS_LOAD && !data_busy &&
                        mem2proc_response != MEM_TAG_NONE) break;
                end
                redirect <= 1'b1;
                redirect_pc <= addrs[i];
                @(posedge clock);
                redirect <= 1'b0;
            end else begin
                data_req <= 1'b1;
                data_write <= (ops[i] == "store");
                data_addr <= addrs[i];
                data_wdata <= datas[i];
                data_dest <= dests[i];
                @(posedge clock);
                data_req <= 1'b0;
                k = 0;
                while (!data_done) begin
                    @(posedge clock);
                    k++;
                    if (k > 200) give_up("data_done");
                end
                if (data_busy) begin
                    $display("** Error at %0t: data_busy still high with data_done", $time);
                    errors = errors + 1;
                end
                if (data_done_dest !== dests[i]) begin
                    $display("** Error at %0t: dest %h, expected %h", $time, data_done_dest,
                             dests[i]);
                    errors = errors + 1;
                end
                if (ops[i] == "load" && data_rdata !== expects[i]) begin
                    $display("** Error at %0t: load %h gave %h, expected %h", $time,
                             addrs[i], data_rdata, expects[i]);
                    errors = errors + 1;
                end
                if (ops[i] == "store" && mem_lines[line_index(addrs[i])][31:0] !== datas[i]) begin
                    $display("** Error at %0t: memory at %h not written", $time, addrs[i]);
                    errors = errors + 1;
                end
            end
            $display("test %0d %s %h: %s", tests, ops[i], addrs[i],
                     (errors == errors_before) ? "ok" : "failed");
        end

        repeat (8) @(posedge clock);   // late fetch pulses still get checked
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: files.f
src/mem_bus_pkg.sv
src/core_pkg.sv
src/tag_waiter.sv
src/fetch_requester.sv
src/data_requester.sv
src/bus_arbiter.sv
src/mem_front_end.sv
bench/mem_front_end_assertions.sv
bench/mem_front_end_tb.sv

// File: src/bus_arbiter.sv
/*
 * Shares the memory bus between fetch and data. Data wins whenever its
 * command is up, fetch takes the bus otherwise. A nonzero response is
 * routed back as an accept strobe to the granted side only.
 */

module bus_arbiter
    import mem_bus_pkg::*, core_pkg::*;
(
    input  bus_command_t fetch_command,
    input  addr_t        fetch_addr,
    input  bus_command_t data_command,
    input  addr_t        data_bus_addr,
    input  word_t        data_bus_wdata,
    input  mem_tag_t     mem2proc_response,
    output bus_command_t proc2mem_command,
    output addr_t        proc2mem_addr,
    output mem_line_t    proc2mem_data,
    output logic         fetch_accept,
    output logic         data_accept,
    output mem_tag_t     accept_tag
);

    logic data_owns;    // data side has the bus this cycle
    logic responded;    // memory took whatever is on the bus

    assign data_owns = (data_command != BUS_NONE);
    assign responded = (mem2proc_response != MEM_TAG_NONE);

    //////////////////////////////////////////////////////////////////////
    // command mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (data_owns) begin
            proc2mem_command = data_command;
            proc2mem_addr    = data_bus_addr;
        end else begin
            proc2mem_command = fetch_command;    // fetch retries when it loses
            proc2mem_addr    = fetch_addr;
        end
    end

    // store word rides in the low half
    assign proc2mem_data = {{(MEM_LINE_BITS-XLEN){1'b0}}, data_bus_wdata};

    //////////////////////////////////////////////////////////////////////
    // accept routing
    //////////////////////////////////////////////////////////////////////

    assign data_accept  = responded && data_owns;
    assign fetch_accept = responded && !data_owns && (fetch_command != BUS_NONE);
    assign accept_tag   = mem2proc_response;

endmodule

// File: src/core_pkg.sv
/*
 * Processor side definitions: address, data word and register index.
 * Imported by the requesters, the arbiter and the top level.
 */

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN         = 32;  // address and data width
    localparam int REG_IDX_BITS = 5;   // 32 architectural registers

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]         addr_t;
    typedef logic [XLEN-1:0]         word_t;
    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;

    // first line fetched once reset drops
    localparam addr_t FETCH_RESET_PC = '0;

endpackage

// File: src/data_requester.sv
/*
 * Data side of the memory bus. Takes one load or store at a time, holds
 * its command on the bus until memory accepts it, then finishes with a
 * data_done pulse. Stores finish on acceptance, loads on the tag return.
 */

module data_requester
    import mem_bus_pkg::*, core_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         data_req,        // strobe, only seen while idle
    input  logic         data_write,      // 1 store, 0 load
    input  addr_t        data_addr,
    input  word_t        data_wdata,
    input  reg_idx_t     data_dest,
    input  logic         accept,
    input  mem_tag_t     accept_tag,
    input  mem_tag_t     mem2proc_tag,
    input  mem_line_t    mem2proc_data,
    output bus_command_t data_command,
    output addr_t        data_bus_addr,
    output word_t        data_bus_wdata,
    output logic         data_busy,
    output logic         data_done,
    output word_t        data_rdata,
    output reg_idx_t     data_done_dest
);

    logic      pending;        // command up, not accepted yet
    logic      store_done_q;   // store finished last cycle
    logic      write_q;
    addr_t     addr_q;
    word_t     wdata_q;
    reg_idx_t  dest_q;
    logic      take;           // new request latched this cycle
    logic      accepted;
    logic      load_waiting;
    logic      load_done;
    reg_idx_t  load_dest;
    mem_line_t load_line;

    assign take     = data_req && !data_busy;
    assign accepted = accept && pending;

    // busy covers the bus phase and the wait for the load return
    assign data_busy = pending || load_waiting;

    assign data_command   = !pending ? BUS_NONE : (write_q ? BUS_STORE : BUS_LOAD);
    assign data_bus_addr  = addr_q;
    assign data_bus_wdata = wdata_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending      <= 1'b0;
            store_done_q <= 1'b0;
        end else begin
            store_done_q <= accepted && write_q;   // stores end at accept
            if (take) begin
                pending <= 1'b1;
            end else if (accepted) begin
                pending <= 1'b0;
            end
        end
    end

    // request payload, no reset needed
    always_ff @(posedge clock) begin
        if (take) begin
            write_q <= data_write;
            addr_q  <= data_addr;
            wdata_q <= data_wdata;
            dest_q  <= data_dest;
        end
    end

    tag_waiter #(
        .payload_t (reg_idx_t)
    ) i_load_waiter (
        .clock         (clock),
        .reset         (reset),
        .arm           (accepted && !write_q),
        .arm_tag       (accept_tag),
        .arm_payload   (dest_q),
        .flush         (1'b0),          // loads are never squashed here
        .mem2proc_tag  (mem2proc_tag),
        .mem2proc_data (mem2proc_data),
        .waiting       (load_waiting),
        .done          (load_done),
        .done_payload  (load_dest),
        .done_data     (load_line)
    );

    // completion, store echoes its own word
    assign data_done      = load_done || store_done_q;
    assign data_rdata     = store_done_q ? wdata_q : load_line[XLEN-1:0];
    assign data_done_dest = store_done_q ? dest_q : load_dest;

endmodule

// File: src/fetch_requester.sv
/*
 * Instruction fetch side of the memory bus. Walks the fetch PC one line
 * at a time, keeps one load outstanding and reports each returned line
 * with its PC. A redirect reloads the PC and drops the pending return.
 */

module fetch_requester
    import mem_bus_pkg::*, core_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         redirect,       // strobe
    input  addr_t        redirect_pc,
    input  logic         fetch_stall,    // level, holds off new loads only
    input  logic         accept,         // granted and accepted this cycle
    input  mem_tag_t     accept_tag,
    input  mem_tag_t     mem2proc_tag,
    input  mem_line_t    mem2proc_data,
    output bus_command_t fetch_command,
    output addr_t        fetch_addr,
    output logic         fetch_valid,
    output addr_t        fetch_pc,
    output mem_line_t    fetch_line
);

    addr_t pc_q;        // next line to request
    logic  running;     // low for the first cycle out of reset
    logic  waiting;     // load accepted, return not seen yet
    logic  arm;

    //////////////////////////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////////////////////////

    assign fetch_command = (running && !fetch_stall && !waiting) ? BUS_LOAD
                                                                 : BUS_NONE;
    assign fetch_addr    = pc_q;

    // redirect beats an acceptance in the same cycle
    assign arm = accept && !redirect;

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            pc_q    <= FETCH_RESET_PC;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                pc_q <= redirect_pc;                       // squash restart
            end else if (accept) begin
                pc_q <= pc_q + addr_t'(MEM_LINE_BYTES);    // next line
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // return
    //////////////////////////////////////////////////////////////////////

    // payload is the PC of the line in flight
    tag_waiter #(
        .payload_t (addr_t)
    ) i_fetch_waiter (
        .clock         (clock),
        .reset         (reset),
        .arm           (arm),
        .arm_tag       (accept_tag),
        .arm_payload   (pc_q),
        .flush         (redirect),      // stale return gets ignored
        .mem2proc_tag  (mem2proc_tag),
        .mem2proc_data (mem2proc_data),
        .waiting       (waiting),
        .done          (fetch_valid),
        .done_payload  (fetch_pc),
        .done_data     (fetch_line)
    );

endmodule

// File: src/mem_bus_pkg.sv
/*
 * Memory bus definitions: command codes, tag and line types.
 * Shared by every block that drives or watches the memory bus.
 */

package mem_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int MEM_TAG_BITS  = 4;   // response and return tag
    localparam int MEM_LINE_BITS = 64;  // one bus data word

    // fetch walks memory one line at a time
    localparam int unsigned MEM_LINE_BYTES = MEM_LINE_BITS / 8;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,  // idle bus
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    typedef logic [MEM_TAG_BITS-1:0]  mem_tag_t;
    typedef logic [MEM_LINE_BITS-1:0] mem_line_t;

    // zero response is a retry, zero return tag carries nothing
    localparam mem_tag_t MEM_TAG_NONE = '0;

endpackage

// File: src/mem_front_end.sv
/*
 * Memory facing front end: a fetch requester and a data requester
 * sharing one memory bus through the arbiter, data side first.
 */

module mem_front_end
    import mem_bus_pkg::*, core_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    // memory bus
    input  mem_tag_t     mem2proc_response,
    input  mem_line_t    mem2proc_data,
    input  mem_tag_t     mem2proc_tag,
    output bus_command_t proc2mem_command,
    output addr_t        proc2mem_addr,
    output mem_line_t    proc2mem_data,
    // fetch side
    input  logic         redirect,
    input  addr_t        redirect_pc,
    input  logic         fetch_stall,
    output logic         fetch_valid,
    output addr_t        fetch_pc,
    output mem_line_t    fetch_line,
    // data side
    input  logic         data_req,
    input  logic         data_write,
    input  addr_t        data_addr,
    input  word_t        data_wdata,
    input  reg_idx_t     data_dest,
    output logic         data_busy,
    output logic         data_done,
    output word_t        data_rdata,
    output reg_idx_t     data_done_dest
);

    bus_command_t fetch_command;
    addr_t        fetch_addr;
    bus_command_t data_command;
    addr_t        data_bus_addr;
    word_t        data_bus_wdata;
    logic         fetch_accept;
    logic         data_accept;
    mem_tag_t     accept_tag;     // shared, only the granted side looks

    fetch_requester i_fetch_requester (
        .clock         (clock),
        .reset         (reset),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .fetch_stall   (fetch_stall),
        .accept        (fetch_accept),
        .accept_tag    (accept_tag),
        .mem2proc_tag  (mem2proc_tag),
        .mem2proc_data (mem2proc_data),
        .fetch_command (fetch_command),
        .fetch_addr    (fetch_addr),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_line    (fetch_line)
    );

    data_requester i_data_requester (
        .clock          (clock),
        .reset          (reset),
        .data_req       (data_req),
        .data_write     (data_write),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_dest      (data_dest),
        .accept         (data_accept),
        .accept_tag     (accept_tag),
        .mem2proc_tag   (mem2proc_tag),
        .mem2proc_data  (mem2proc_data),
        .data_command   (data_command),
        .data_bus_addr  (data_bus_addr),
        .data_bus_wdata (data_bus_wdata),
        .data_busy      (data_busy),
        .data_done      (data_done),
        .data_rdata     (data_rdata),
        .data_done_dest (data_done_dest)
    );

    bus_arbiter i_bus_arbiter (
        .fetch_command     (fetch_command),
        .fetch_addr        (fetch_addr),
        .data_command      (data_command),
        .data_bus_addr     (data_bus_addr),
        .data_bus_wdata    (data_bus_wdata),
        .mem2proc_response (mem2proc_response),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .fetch_accept      (fetch_accept),
        .data_accept       (data_accept),
        .accept_tag        (accept_tag)
    );

endmodule

// File: src/tag_waiter.sv
/*
 * Holds one outstanding memory tag with a caller payload and catches
 * the return carrying that tag. A match gives a one cycle done pulse
 * with the payload and the returned line. Flush forgets the tag.
 */

module tag_waiter
    import mem_bus_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      arm,           // request accepted this cycle
    input  mem_tag_t  arm_tag,       // tag memory handed back
    input  payload_t  arm_payload,
    input  logic      flush,         // drop whatever is outstanding
    input  mem_tag_t  mem2proc_tag,
    input  mem_line_t mem2proc_data,
    output logic      waiting,
    output logic      done,          // one cycle after the tag cycle
    output payload_t  done_payload,
    output mem_line_t done_data
);

    mem_tag_t held_tag;
    payload_t held_payload;
    logic     tag_hit;

    // tag zero never matches, even against a stale held_tag
    assign tag_hit = waiting && (mem2proc_tag != MEM_TAG_NONE) &&
                     (mem2proc_tag == held_tag);

    // control
    always_ff @(posedge clock) begin
        if (reset) begin
            waiting <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= tag_hit && !flush;  // flush swallows a same cycle hit
            if (flush) begin
                waiting <= 1'b0;
            end else if (arm) begin
                waiting <= 1'b1;
            end else if (tag_hit) begin
                waiting <= 1'b0;
            end
        end
    end

    // tag, payload and returned line
    always_ff @(posedge clock) begin
        if (arm) begin
            held_tag     <= arm_tag;
            held_payload <= arm_payload;
        end
        if (tag_hit) begin
            done_payload <= held_payload;
            done_data    <= mem2proc_data;  // whole line, caller slices
        end
    end

endmodule
